/* camera_settings.svh */
`ifndef CAMERA_SETTINGS_SVH
`define CAMERA_SETTINGS_SVH

// Image buffer depth in bytes
`define CAM_BUF_DEPTH 4096

// Buffer address width
`define CAM_ADDR_W 12

// Image bytes per compression step
`define CAM_SIZE_STEP 16

// Metering channels, red green blue
`define CAM_METER_CHANNELS 3

`endif

/* camera_pkg.sv */
`include "camera_settings.svh"

package camera_pkg;

    // SPI op codes
    typedef enum logic [7:0] {
        op_capture         = 8'h20,
        op_bytes_available = 8'h21,
        op_read_data       = 8'h22,
        op_zoom            = 8'h23,
        op_pan             = 8'h24,
        op_metering        = 8'h25,
        op_quality         = 8'h26,
        op_image_done      = 8'h30,
        op_image_size      = 8'h31
    } op_code_e;

    // Request to the shared image buffer, held until granted
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`CAM_ADDR_W-1:0] addr;
        logic [7:0]             wdata;
    } buf_req_t;

    // Read data is valid the cycle after grant
    typedef struct packed {
        logic       grant;
        logic [7:0] rdata;
    } buf_rsp_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } metering_t;

endpackage

/* spi_target.sv */
module spi_target (
    input  logic                clock_in,
    input  logic                reset_n_in,
    input  logic                spi_sck,
    input  logic                spi_cs_n,
    input  logic                spi_mosi,
    output logic                spi_miso,
    output camera_pkg::op_code_e op_code,
    output logic                op_code_valid,
    output logic                operand_valid,
    output logic [7:0]          operand,
    output logic [7:0]          operand_count,
    input  logic [7:0]          response,
    input  logic                response_valid
);

    import camera_pkg::*;

    logic [2:0] sck_pipe;
    logic [1:0] cs_pipe;
    logic [1:0] mosi_pipe;
    logic       sck_rise;
    logic       sck_fall;
    logic       selected;
    logic [2:0] bit_count;
    logic [6:0] shift_in;
    logic [7:0] shift_out;
    logic [7:0] rx_byte;
    logic       byte_done;

    // Two sync flops, third stage only for edge detect
    assign sck_rise  = sck_pipe[1] & ~sck_pipe[2];
    assign sck_fall  = ~sck_pipe[1] & sck_pipe[2];
    assign selected  = ~cs_pipe[1];
    assign rx_byte   = {shift_in, mosi_pipe[1]};
    assign byte_done = selected & sck_rise & (bit_count == 3'd7);
    assign spi_miso  = shift_out[7];

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            sck_pipe      <= 3'b000;
            cs_pipe       <= 2'b11;
            mosi_pipe     <= 2'b00;
            bit_count     <= 3'd0;
            op_code_valid <= 1'b0;
            operand_valid <= 1'b0;
            operand_count <= 8'd0;
            shift_out     <= 8'h00;
        end else begin
            sck_pipe      <= {sck_pipe[1:0], spi_sck};
            cs_pipe       <= {cs_pipe[0], spi_cs_n};
            mosi_pipe     <= {mosi_pipe[0], spi_mosi};
            operand_valid <= 1'b0;
            if (!selected) begin
                bit_count     <= 3'd0;
                op_code_valid <= 1'b0;
                operand_count <= 8'd0;
                shift_out     <= 8'h00;
            end else begin
                if (sck_rise) begin
                    bit_count <= bit_count + 3'd1;
                end
                if (byte_done && !op_code_valid) begin
                    op_code_valid <= 1'b1;
                end else if (byte_done) begin
                    operand_valid <= 1'b1;
                    operand_count <= operand_count + 8'd1;
                end
                // Falling edge after a full byte starts the next response byte
                if (sck_fall) begin
                    if (bit_count == 3'd0) begin
                        shift_out <= response_valid ? response : 8'h00;
                    end else begin
                        shift_out <= {shift_out[6:0], 1'b0};
                    end
                end
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (selected && sck_rise) begin
            shift_in <= rx_byte[6:0];
        end
        if (byte_done && !op_code_valid) begin
            op_code <= op_code_e'(rx_byte);
        end
        if (byte_done && op_code_valid) begin
            operand <= rx_byte;
        end
    end

    // Operand bytes only follow an op code within one transaction
    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        $rose(operand_valid) |-> op_code_valid);

endmodule

/* spi_registers.sv */
`include "camera_settings.svh"

module spi_registers (
    input  logic                 clock_in,
    input  logic                 reset_n_in,
    input  camera_pkg::op_code_e op_code,
    input  logic                 op_code_valid,
    input  logic [7:0]           operand,
    input  logic                 operand_valid,
    input  logic [7:0]           operand_count,
    output logic [7:0]           response,
    output logic                 response_valid,
    output logic                 start_capture,
    output logic [3:0]           compression_factor,
    input  logic [15:0]          image_size,
    input  logic                 image_complete,
    input  logic [15:0]          bytes_written,
    input  camera_pkg::metering_t metering,
    output camera_pkg::buf_req_t rd_req,
    input  camera_pkg::buf_rsp_t rd_rsp
);

    import camera_pkg::*;

    logic [15:0] bytes_read;
    logic [15:0] bytes_remaining;
    logic        op_code_valid_d;
    logic        op_start;
    logic        fetch_pending;
    logic        fetch_done;
    logic [7:0]  read_byte;

    assign bytes_remaining = bytes_written - bytes_read;
    assign op_start        = op_code_valid & ~op_code_valid_d;

    // Prefetch of the byte at bytes_read
    assign rd_req.valid = fetch_pending;
    assign rd_req.write = 1'b0;
    assign rd_req.addr  = bytes_read[`CAM_ADDR_W-1:0];
    assign rd_req.wdata = 8'h00;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            op_code_valid_d    <= 1'b0;
            start_capture      <= 1'b0;
            compression_factor <= 4'd0;
            bytes_read         <= 16'd0;
            fetch_pending      <= 1'b0;
            fetch_done         <= 1'b0;
            response_valid     <= 1'b0;
        end else begin
            op_code_valid_d <= op_code_valid;
            start_capture   <= 1'b0;
            response_valid  <= 1'b0;
            fetch_done      <= rd_rsp.grant;
            if (rd_rsp.grant) begin
                fetch_pending <= 1'b0;
            end
            if (op_code_valid) begin
                case (op_code)
                    op_capture: begin
                        if (op_start) begin
                            start_capture <= 1'b1;
                            bytes_read    <= 16'd0;
                        end
                    end
                    op_read_data: begin
                        response_valid <= 1'b1;
                        if (op_start) begin
                            fetch_pending <= 1'b1;
                        end else if (operand_valid) begin
                            // Byte went out, move on and fetch the next one
                            if (bytes_read < bytes_written) begin
                                bytes_read <= bytes_read + 16'd1;
                            end
                            fetch_pending <= 1'b1;
                        end
                    end
                    op_quality: begin
                        if (operand_valid) begin
                            compression_factor <= operand[3:0];
                        end
                    end
                    op_bytes_available, op_metering, op_image_done, op_image_size: begin
                        response_valid <= 1'b1;
                    end
                    // Zoom and pan are accepted and ignored
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (fetch_done) begin
            read_byte <= rd_rsp.rdata;
        end
        case (op_code)
            op_bytes_available: begin
                response <= (operand_count == 8'd0) ? bytes_remaining[15:8]
                                                    : bytes_remaining[7:0];
            end
            op_read_data: response <= read_byte;
            op_metering: begin
                case (operand_count)
                    8'd0:    response <= metering.red;
                    8'd1:    response <= metering.green;
                    default: response <= metering.blue;
                endcase
            end
            op_image_done: response <= {7'd0, image_complete};
            op_image_size: begin
                response <= (operand_count == 8'd0) ? image_size[7:0] : image_size[15:8];
            end
            default: response <= 8'h00;
        endcase
    end

    // Reader never runs ahead of the capture writer
    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        bytes_read <= bytes_written);

endmodule

/* capture_writer.sv */
`include "camera_settings.svh"

module capture_writer (
    input  logic                  clock_in,
    input  logic                  reset_n_in,
    input  logic                  start_capture,
    input  logic [3:0]            compression_factor,
    output logic [15:0]           image_size,
    output logic                  image_complete,
    output logic [15:0]           bytes_written,
    output camera_pkg::metering_t metering,
    output camera_pkg::buf_req_t  wr_req,
    input  camera_pkg::buf_rsp_t  wr_rsp
);

    import camera_pkg::*;

    logic        active;
    logic [15:0] count;
    logic [7:0]  value;
    logic [1:0]  channel;
    logic        last_write;

    assign last_write    = (count == image_size - 16'd1);
    assign bytes_written = count;

    assign wr_req.valid = active;
    assign wr_req.write = 1'b1;
    assign wr_req.addr  = count[`CAM_ADDR_W-1:0];
    assign wr_req.wdata = value;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            active         <= 1'b0;
            count          <= 16'd0;
            value          <= 8'h00;
            channel        <= 2'd0;
            image_size     <= 16'd0;
            image_complete <= 1'b0;
            metering       <= '0;
        end else if (start_capture) begin
            active         <= 1'b1;
            count          <= 16'd0;
            value          <= {4'h0, compression_factor};
            channel        <= 2'd0;
            image_complete <= 1'b0;
            metering       <= '0;
            // Higher factor gives a smaller image
            image_size <= 16'(`CAM_SIZE_STEP) * (16'd16 - {12'h000, compression_factor});
        end else if (active && wr_rsp.grant) begin
            count <= count + 16'd1;
            value <= value + 8'd5;
            if (channel == 2'(`CAM_METER_CHANNELS - 1)) begin
                channel <= 2'd0;
            end else begin
                channel <= channel + 2'd1;
            end
            // Running maximum per channel
            case (channel)
                2'd0:    if (value > metering.red) metering.red <= value;
                2'd1:    if (value > metering.green) metering.green <= value;
                default: if (value > metering.blue) metering.blue <= value;
            endcase
            if (last_write) begin
                active         <= 1'b0;
                image_complete <= 1'b1;
            end
        end
    end

endmodule

/* image_buffer_arbiter.sv */
`include "camera_settings.svh"

module image_buffer_arbiter (
    input  logic                 clock_in,
    input  logic                 reset_n_in,
    input  camera_pkg::buf_req_t wr_req,
    input  camera_pkg::buf_req_t rd_req,
    output camera_pkg::buf_rsp_t wr_rsp,
    output camera_pkg::buf_rsp_t rd_rsp
);

    import camera_pkg::*;

    logic [7:0] mem [`CAM_BUF_DEPTH];
    logic [7:0] rdata_q;
    logic       wr_grant;
    logic       rd_grant;
    buf_req_t   port_req;

    // Fixed priority, the writer always wins
    assign wr_grant = wr_req.valid;
    assign rd_grant = rd_req.valid & ~wr_req.valid;

    // Single port shared by whichever peer holds the grant
    assign port_req = wr_grant ? wr_req : rd_req;

    assign wr_rsp.grant = wr_grant;
    assign wr_rsp.rdata = rdata_q;
    assign rd_rsp.grant = rd_grant;
    assign rd_rsp.rdata = rdata_q;

    always_ff @(posedge clock_in) begin
        if (port_req.valid) begin
            if (port_req.write) begin
                mem[port_req.addr] <= port_req.wdata;
            end else begin
                rdata_q <= mem[port_req.addr];
            end
        end
    end

    // One access per cycle on the single port
    assert property (@(posedge clock_in) disable iff (!reset_n_in)
        !(wr_rsp.grant && rd_rsp.grant));

endmodule

/* camera_subsystem.sv */
module camera_subsystem (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic spi_sck,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    output logic spi_miso
);

    import camera_pkg::*;

    op_code_e    op_code;
    logic        op_code_valid;
    logic [7:0]  operand;
    logic        operand_valid;
    logic [7:0]  operand_count;
    logic [7:0]  response;
    logic        response_valid;
    logic        start_capture;
    logic [3:0]  compression_factor;
    logic [15:0] image_size;
    logic        image_complete;
    logic [15:0] bytes_written;
    metering_t   metering;
    buf_req_t    wr_req;
    buf_req_t    rd_req;
    buf_rsp_t    wr_rsp;
    buf_rsp_t    rd_rsp;

    spi_target u_spi_target (
        .clock_in       (clock_in),
        .reset_n_in     (reset_n_in),
        .spi_sck        (spi_sck),
        .spi_cs_n       (spi_cs_n),
        .spi_mosi       (spi_mosi),
        .spi_miso       (spi_miso),
        .op_code        (op_code),
        .op_code_valid  (op_code_valid),
        .operand_valid  (operand_valid),
        .operand        (operand),
        .operand_count  (operand_count),
        .response       (response),
        .response_valid (response_valid)
    );

    spi_registers u_spi_registers (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .op_code            (op_code),
        .op_code_valid      (op_code_valid),
        .operand            (operand),
        .operand_valid      (operand_valid),
        .operand_count      (operand_count),
        .response           (response),
        .response_valid     (response_valid),
        .start_capture      (start_capture),
        .compression_factor (compression_factor),
        .image_size         (image_size),
        .image_complete     (image_complete),
        .bytes_written      (bytes_written),
        .metering           (metering),
        .rd_req             (rd_req),
        .rd_rsp             (rd_rsp)
    );

    capture_writer u_capture_writer (
        .clock_in           (clock_in),
        .reset_n_in         (reset_n_in),
        .start_capture      (start_capture),
        .compression_factor (compression_factor),
        .image_size         (image_size),
        .image_complete     (image_complete),
        .bytes_written      (bytes_written),
        .metering           (metering),
        .wr_req             (wr_req),
        .wr_rsp             (wr_rsp)
    );

    image_buffer_arbiter u_image_buffer_arbiter (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .wr_req     (wr_req),
        .rd_req     (rd_req),
        .wr_rsp     (wr_rsp),
        .rd_rsp     (rd_rsp)
    );

endmodule

/* camera_subsystem_tb.sv */
module camera_subsystem_tb;

    localparam int HALF_SCK  = 32;
    localparam int MAX_POLLS = 2000;
    localparam int MAX_LINES = 500;
    localparam int MAX_BYTES = 16;

    logic clock_in;
    logic reset_n_in;
    logic spi_sck;
    logic spi_cs_n;
    logic spi_mosi;
    logic spi_miso;

    // Op code byte at index 0 and operand bytes after it
    logic [7:0] frame     [MAX_BYTES];
    logic [7:0] rx_frame  [MAX_BYTES];
    logic [7:0] stim_exp  [MAX_BYTES];
    logic [7:0] model_exp [MAX_BYTES];

    int check_count;
    int fail_count;
    int test_count;
    int test_checks;
    int test_fails;
    int current_test;
    bit stop_run;

    // Reference camera state
    int model_factor;
    int model_cap_factor;
    int model_size;
    int model_read_pos;
    bit model_captured;

    camera_subsystem uut (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .spi_sck    (spi_sck),
        .spi_cs_n   (spi_cs_n),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    initial begin
        clock_in = 1'b0;
        forever #4 clock_in = ~clock_in;
    end

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock_in);
        #1;
    endtask

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            fail_count++;
            test_fails++;
            $display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        fail_count++;
        test_fails++;
        $display("%s", msg);
    endtask

    task automatic finish_test();
        test_count++;
        if (test_fails == 0) begin
            $display("test %0d passed, %0d checks", current_test, test_checks);
        end else begin
            $display("test %0d failed, %0d of %0d checks wrong",
                     current_test, test_fails, test_checks);
        end
        test_checks = 0;
        test_fails  = 0;
    endtask

    // Byte i of a capture is i*5 plus the factor
    function automatic logic [7:0] image_byte(input int factor, input int index);
        return 8'((index * 5 + factor) % 256);
    endfunction

    function automatic logic [7:0] channel_max(input int factor, input int size, input int ch);
        logic [7:0] best;
        best = 8'h00;
        for (int i = ch; i < size; i += 3) begin
            if (image_byte(factor, i) > best) begin
                best = image_byte(factor, i);
            end
        end
        return best;
    endfunction

    task automatic predict_response(input int op, input int count);
        int remaining;
        remaining = model_size - model_read_pos;
        for (int i = 1; i <= count; i++) begin
            case (op)
                'h21: model_exp[i] = (i == 1) ? 8'(remaining >> 8) : 8'(remaining);
                'h22: begin
                    model_exp[i] = image_byte(model_cap_factor, model_read_pos);
                    if (model_read_pos < model_size) begin
                        model_read_pos++;
                    end
                end
                'h25: begin
                    model_exp[i] = channel_max(model_cap_factor, model_size,
                                               (i > 3) ? 2 : i - 1);
                end
                'h26: begin
                    model_exp[i] = 8'h00;
                    model_factor = int'(frame[i][3:0]);
                end
                'h30: model_exp[i] = {7'd0, model_captured};
                'h31: model_exp[i] = (i == 1) ? 8'(model_size) : 8'(model_size >> 8);
                // Capture, zoom and pan give no response
                default: model_exp[i] = 8'h00;
            endcase
        end
        if (op == 'h20) begin
            model_cap_factor = model_factor;
            model_size       = 16 * (16 - model_factor);
            model_read_pos   = 0;
            model_captured   = 1'b1;
        end
    endtask

    // Mode 0 with mosi changing while sck is low and miso taken at the rising edge
    task automatic spi_transfer(input int count);
        logic [7:0] rx;
        spi_cs_n = 1'b0;
        wait_clocks(HALF_SCK);
        for (int b = 0; b <= count; b++) begin
            rx = 8'h00;
            for (int k = 7; k >= 0; k--) begin
                spi_mosi = frame[b][k];
                wait_clocks(HALF_SCK);
                spi_sck = 1'b1;
                rx[k]   = spi_miso;
                wait_clocks(HALF_SCK);
                spi_sck = 1'b0;
            end
            rx_frame[b] = rx;
        end
        wait_clocks(HALF_SCK);
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        wait_clocks(2 * HALF_SCK);
    endtask

    task automatic run_line(input int kind, input int op, input int count, input int line_no);
        bit matched;
        int polls;
        predict_response(op, count);
        for (int i = 1; i <= count; i++) begin
            check_value($sformatf("stim line %0d byte %0d", line_no, i),
                        stim_exp[i], model_exp[i]);
        end
        matched = 1'b0;
        polls   = 0;
        // Kind 1 repeats the transaction until the response matches
        while (!matched && polls < ((kind == 1) ? MAX_POLLS : 1)) begin
            spi_transfer(count);
            polls++;
            matched = 1'b1;
            for (int i = 1; i <= count; i++) begin
                if (rx_frame[i] !== stim_exp[i]) begin
                    matched = 1'b0;
                end
            end
        end
        if (kind == 1) begin
            if (!matched) begin
                report_error($sformatf("timeout: op 0x%02h gave no expected response in %0d polls",
                                       op, MAX_POLLS));
                stop_run = 1'b1;
            end
        end else begin
            for (int i = 1; i <= count; i++) begin
                check_value($sformatf("spi_miso byte %0d of op 0x%02h", i, op),
                            rx_frame[i], stim_exp[i]);
            end
        end
    endtask

    task automatic run_stimulus(input int fd);
        string tok;
        string rest;
        int    status;
        int    test_id;
        int    kind;
        int    op;
        int    count;
        int    value;
        int    line_no;
        bit    bad;
        line_no = 0;
        while (!stop_run) begin
            status = $fscanf(fd, "%s", tok);
            if (status != 1) begin
                stop_run = 1'b1;
            end else if (tok.substr(0, 0) == "#") begin
                status = $fgets(rest, fd);
            end else begin
                line_no++;
                test_id = tok.atoi();
                if (test_id != current_test) begin
                    finish_test();
                    current_test = test_id;
                end
                bad = ($fscanf(fd, "%h %h %h", kind, op, count) != 3);
                bad = bad || count >= MAX_BYTES || line_no > MAX_LINES;
                frame[0] = 8'(op);
                for (int i = 1; i <= count && !bad; i++) begin
                    bad = ($fscanf(fd, "%h", value) != 1);
                    frame[i] = 8'(value);
                end
                for (int i = 1; i <= count && !bad; i++) begin
                    bad = ($fscanf(fd, "%h", value) != 1);
                    stim_exp[i] = 8'(value);
                end
                if (bad) begin
                    report_error($sformatf("stimulus line %0d could not be read", line_no));
                    stop_run = 1'b1;
                end else begin
                    run_line(kind, op, count, line_no);
                end
            end
        end
        finish_test();
    endtask

    initial begin
        int fd;
        check_count      = 0;
        fail_count       = 0;
        test_count       = 0;
        test_checks      = 0;
        test_fails       = 0;
        current_test     = 1;
        stop_run         = 1'b0;
        model_factor     = 0;
        model_cap_factor = 0;
        model_size       = 0;
        model_read_pos   = 0;
        model_captured   = 1'b0;
        reset_n_in       = 1'b0;
        spi_sck          = 1'b0;
        spi_cs_n         = 1'b1;
        spi_mosi         = 1'b0;
        wait_clocks(2);
        reset_n_in = 1'b1;
        wait_clocks(4);
        check_value("spi_miso", {7'd0, spi_miso}, 8'h00);
        fd = $fopen("camera_subsystem_stim.txt", "r");
        if (fd == 0) begin
            report_error("could not open camera_subsystem_stim.txt");
        end else begin
            run_stimulus(fd);
            $fclose(fd);
        end
        $display("tests %0d, checks %0d, failures %0d", test_count, check_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* camera_subsystem_stim.txt */
# test kind op count, then count operand bytes and count expected response bytes (hex)
# kind 0 runs once, kind 1 repeats until the response matches
1 0 30 1 00 00
1 0 21 2 00 00 00 00
2 0 26 1 0c 00
2 0 20 0
2 1 30 1 00 01
2 0 31 2 00 00 40 00
3 0 25 3 00 00 00 fc f2 f7
4 0 21 2 00 00 00 40
4 0 22 8 00 00 00 00 00 00 00 00 0c 11 16 1b 20 25 2a 2f
4 0 22 8 00 00 00 00 00 00 00 00 34 39 3e 43 48 4d 52 57
4 0 22 8 00 00 00 00 00 00 00 00 5c 61 66 6b 70 75 7a 7f
4 0 22 8 00 00 00 00 00 00 00 00 84 89 8e 93 98 9d a2 a7
4 0 22 8 00 00 00 00 00 00 00 00 ac b1 b6 bb c0 c5 ca cf
4 0 22 8 00 00 00 00 00 00 00 00 d4 d9 de e3 e8 ed f2 f7
4 0 22 8 00 00 00 00 00 00 00 00 fc 01 06 0b 10 15 1a 1f
4 0 22 8 00 00 00 00 00 00 00 00 24 29 2e 33 38 3d 42 47
4 0 21 2 00 00 00 00
5 0 23 1 02 00
5 0 24 2 01 03 00 00
5 0 31 2 00 00 40 00
5 0 25 3 00 00 00 fc f2 f7
5 0 21 2 00 00 00 00
5 0 26 1 00 00
5 0 20 0
5 1 30 1 00 01
5 0 31 2 00 00 00 01
5 0 22 4 00 00 00 00 00 05 0a 0f
5 0 21 2 00 00 00 fc

/* camera_subsystem.f */
+incdir+.
camera_pkg.sv
spi_target.sv
spi_registers.sv
capture_writer.sv
image_buffer_arbiter.sv
camera_subsystem.sv
camera_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the camera subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary --timing --assert --top-module camera_subsystem_tb \
        -f camera_subsystem.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vcamera_subsystem_tb > "$log_file" 2>&1; then
    cat "$log_file"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$log_file"

if ! grep -qx "=== PASS ===" "$log_file"; then
    echo "Pass line not found in $log_file"
    exit 1
fi

exit 0
